/* hw/fir_stream_pkg.sv */
// FIR stream data types
package fir_stream_pkg;

  //////////////////////////////////////////////////
  // Data widths

  // One input sample and one coefficient share this width
  localparam int sample_w = 16;

  // Widest tap address supported, so a run has at most 256 taps
  localparam int max_tap_aw = 8;

  // Full precision product of a sample and a coefficient
  localparam int prod_w = 2 * sample_w;

  // Guard bits cover the sum of up to 2^max_tap_aw products
  localparam int acc_w = prod_w + max_tap_aw;

  //////////////////////////////////////////////////
  // Stream payloads

  // One signed sample on the sample port
  typedef struct packed {
    logic signed [sample_w-1:0] data;
  } sample_t;

  // One filter output and the end of frame marker
  typedef struct packed {
    logic signed [acc_w-1:0] value;
    logic                    last;
  } result_t;

endpackage

/* hw/fir_cfg_pkg.sv */
// FIR command and run configuration
package fir_cfg_pkg;

  //////////////////////////////////////////////////
  // Configuration limits

  // Frame length field of a run command
  localparam int frame_len_w = 16;

  // Unused bits at the bottom of every command word
  localparam int cmd_pad_w = 6;

  // Opcode in the top two bits of a command word
  typedef enum logic [1:0] {
    op_nop       = 2'd0,
    op_tap_write = 2'd1,
    op_run       = 2'd2
  } cmd_op_e;

  //////////////////////////////////////////////////
  // Command word, read according to its opcode

  // Loads one coefficient into the bank
  typedef struct packed {
    cmd_op_e                                   op;
    logic [fir_stream_pkg::max_tap_aw-1:0]     addr;
    logic signed [fir_stream_pkg::sample_w-1:0] coef;
    logic [cmd_pad_w-1:0]                      pad;
  } cmd_tap_write_t;

  // Launches a run with a tap count and a frame length
  typedef struct packed {
    cmd_op_e                               op;
    logic [fir_stream_pkg::max_tap_aw-1:0] tap_num;
    logic [frame_len_w-1:0]                frame_len;
    logic [cmd_pad_w-1:0]                  pad;
  } cmd_run_t;

  // Both views are 32 bits and place the opcode at the same bits
  typedef union packed {
    cmd_tap_write_t tap_write;
    cmd_run_t       run;
  } cmd_word_u;

  // Run parameters held stable by the decoder through a run
  typedef struct packed {
    logic [fir_stream_pkg::max_tap_aw-1:0] tap_num;
    logic [frame_len_w-1:0]                frame_len;
  } run_cfg_t;

endpackage

/* hw/fir_cmd_decoder.sv */
// FIR command decoder
module fir_cmd_decoder #(
  parameter int tap_aw = 5
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       cmd_req,
  output logic                                       cmd_ack,
  input  fir_cfg_pkg::cmd_word_u                     cmd,
  input  logic                                       busy,
  output logic                                       coef_we,
  output logic [tap_aw-1:0]                          coef_addr,
  output logic signed [fir_stream_pkg::sample_w-1:0] coef_data,
  output logic                                       start,
  output fir_cfg_pkg::run_cfg_t                      cfg
);
  import fir_cfg_pkg::*;

  // Waiting for a request, or holding ack until the request drops
  typedef enum logic {
    dec_idle,
    dec_ack
  } dec_state_e;

  dec_state_e state;
  logic       take;
  cmd_op_e    op;

  // Both views of the union keep the opcode in the same place
  assign op = cmd.tap_write.op;

  // A command is taken only while the core sits idle
  assign take = (state == dec_idle) && cmd_req && !busy;

  assign cmd_ack = (state == dec_ack);

  //////////////////////////////////////////////////
  // Handshake and strobes

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= dec_idle;
      coef_we <= 1'b0;
      start   <= 1'b0;
    end else begin
      // Strobes rise together with ack and last one cycle
      coef_we <= take && (op == op_tap_write);
      start   <= take && (op == op_run);
      if (take) begin
        state <= dec_ack;
      end else if ((state == dec_ack) && !cmd_req) begin
        // Source has seen ack, so the exchange is over
        state <= dec_idle;
      end
    end
  end

  //////////////////////////////////////////////////
  // Decoded fields

  always_ff @(posedge clk) begin
    if (take) begin
      coef_addr <= cmd.tap_write.addr[tap_aw-1:0];
      coef_data <= cmd.tap_write.coef;
    end
    // Run parameters stay put until the next run command
    if (take && (op == op_run)) begin
      cfg.tap_num   <= cmd.run.tap_num;
      cfg.frame_len <= cmd.run.frame_len;
    end
  end

endmodule

/* hw/fir_coef_bank.sv */
// FIR coefficient bank
module fir_coef_bank #(
  parameter int tap_aw = 5
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       coef_we,
  input  logic [tap_aw-1:0]                          coef_addr,
  input  logic signed [fir_stream_pkg::sample_w-1:0] coef_data,
  input  logic [tap_aw-1:0]                          rd_addr,
  output logic signed [fir_stream_pkg::sample_w-1:0] rd_coef
);
  import fir_stream_pkg::*;

  localparam int depth = 2 ** tap_aw;

  // One signed coefficient per tap, h[0] at address 0
  logic signed [sample_w-1:0] coef_q [depth];

  // Unloaded taps read as zero after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < depth; i++) begin
        coef_q[i] <= '0;
      end
    end else if (coef_we) begin
      coef_q[coef_addr] <= coef_data;
    end
  end

  // Core reads one tap per cycle with no read latency
  assign rd_coef = coef_q[rd_addr];

endmodule

/* hw/fir_delay_line.sv */
// FIR sample history
module fir_delay_line #(
  parameter int tap_aw = 5
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       smp_req,
  output logic                                       smp_ack,
  input  fir_stream_pkg::sample_t                    smp,
  input  logic                                       clr_start,
  input  logic [fir_stream_pkg::max_tap_aw-1:0]      tap_num,
  output logic                                       clr_done,
  output logic                                       smp_valid,
  input  logic                                       smp_take,
  input  logic [tap_aw-1:0]                          rd_offset,
  output logic signed [fir_stream_pkg::sample_w-1:0] rd_data
);
  import fir_stream_pkg::*;

  localparam int depth = 2 ** tap_aw;

  // Circular history, wr_ptr marks the newest sample
  logic signed [sample_w-1:0] hist_q [depth];
  logic [tap_aw-1:0]          wr_ptr;
  logic [tap_aw-1:0]          rd_addr;
  logic [tap_aw-1:0]          clr_addr;
  logic [max_tap_aw-1:0]      clr_cnt;
  logic                       clearing;
  logic                       blocked;
  logic                       accept;

  // Blocked stays set from an accepted sample until the core releases it
  assign accept = smp_req && !smp_ack && !clearing && !blocked;

  // Clear walks backwards from the newest entry over the run's tap window
  assign clr_addr = wr_ptr - clr_cnt[tap_aw-1:0];

  // Offset 0 is x[n], offset k is x[n-k]
  assign rd_addr = wr_ptr - rd_offset;
  assign rd_data = hist_q[rd_addr];

  //////////////////////////////////////////////////
  // Clear sequence and sample handshake

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clearing  <= 1'b0;
      clr_cnt   <= '0;
      clr_done  <= 1'b0;
      smp_ack   <= 1'b0;
      smp_valid <= 1'b0;
      // Nothing enters until the core opens a run
      blocked   <= 1'b1;
      wr_ptr    <= '0;
    end else begin
      clr_done  <= 1'b0;
      smp_valid <= accept;
      if (clr_start) begin
        clearing <= 1'b1;
        clr_cnt  <= '0;
      end else if (clearing) begin
        // Last zero write of tap_num, done pulses as the clear ends
        if (clr_cnt == tap_num - 1'b1) begin
          clearing <= 1'b0;
          clr_done <= 1'b1;
        end
        clr_cnt <= clr_cnt + 1'b1;
      end
      if (accept) begin
        smp_ack <= 1'b1;
        wr_ptr  <= wr_ptr + 1'b1;
      end else if (smp_ack && !smp_req) begin
        smp_ack <= 1'b0;
      end
      if (accept) begin
        blocked <= 1'b1;
      end else if (smp_take) begin
        blocked <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // History storage

  // Clear and sample writes never overlap since intake waits for the clear
  always_ff @(posedge clk) begin
    if (clearing) begin
      hist_q[clr_addr] <= '0;
    end else if (accept) begin
      hist_q[wr_ptr + 1'b1] <= smp.data;
    end
  end

endmodule

/* hw/fir_mac_core.sv */
// FIR multiply-accumulate core
module fir_mac_core #(
  parameter int tap_aw     = 5,
  parameter int mul_stages = 2
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       start,
  input  fir_cfg_pkg::run_cfg_t                      cfg,
  output logic                                       busy,
  output logic                                       done,
  output logic                                       clr_start,
  input  logic                                       clr_done,
  input  logic                                       smp_valid,
  output logic                                       smp_take,
  output logic [tap_aw-1:0]                          rd_offset,
  input  logic signed [fir_stream_pkg::sample_w-1:0] rd_data,
  output logic [tap_aw-1:0]                          coef_addr,
  input  logic signed [fir_stream_pkg::sample_w-1:0] coef,
  output logic                                       res_valid,
  output fir_stream_pkg::result_t                    res_data,
  input  logic                                       res_full
);
  import fir_stream_pkg::*;
  import fir_cfg_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_clear,
    st_calc
  } core_state_e;

  // Control bits that ride alongside each product
  typedef struct packed {
    logic vld;
    logic first;
    logic last;
  } mul_tag_t;

  core_state_e              state;
  logic                     pend_q;
  logic                     sweep_q;
  logic                     sweep_go;
  logic                     last_tap;
  logic [max_tap_aw-1:0]    tap_cnt;
  logic [frame_len_w-1:0]   smp_cnt;
  logic                     frame_last_q;
  mul_tag_t                 tag_in;
  mul_tag_t                 tag_q  [mul_stages];
  logic signed [prod_w-1:0] prod_q [mul_stages];
  mul_tag_t                 tag_out;
  logic signed [prod_w-1:0] prod_out;
  logic signed [acc_w-1:0]  prod_ext;
  logic signed [acc_w-1:0]  acc_nxt;
  logic signed [acc_w-1:0]  acc_q;
  logic                     sum_done;

  assign busy = (state != st_idle);

  //////////////////////////////////////////////////
  // Tap sweep

  // A waiting sample starts only once the result port has room
  assign sweep_go = (state == st_calc) && pend_q && !sweep_q && !res_full;
  assign last_tap = (tap_cnt == cfg.tap_num - 1'b1);

  // Same tap index addresses h[k] and x[n-k]
  assign rd_offset = tap_cnt[tap_aw-1:0];
  assign coef_addr = tap_cnt[tap_aw-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q       <= 1'b0;
      sweep_q      <= 1'b0;
      tap_cnt      <= '0;
      smp_cnt      <= '0;
      frame_last_q <= 1'b0;
    end else begin
      if (smp_valid) begin
        pend_q <= 1'b1;
      end
      if (start && (state == st_idle)) begin
        smp_cnt <= '0;
      end
      if (sweep_go) begin
        pend_q       <= 1'b0;
        sweep_q      <= 1'b1;
        tap_cnt      <= '0;
        smp_cnt      <= smp_cnt + 1'b1;
        // Sample number frame_len closes the frame
        frame_last_q <= (smp_cnt + 1'b1 == cfg.frame_len);
      end else if (sweep_q) begin
        if (last_tap) begin
          sweep_q <= 1'b0;
          tap_cnt <= '0;
        end else begin
          tap_cnt <= tap_cnt + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Multiplier pipe

  assign tag_in.vld   = sweep_q;
  assign tag_in.first = (tap_cnt == '0);
  assign tag_in.last  = last_tap;

  // Stage 0 registers the product, later stages only delay it
  for (genvar i = 0; i < mul_stages; i++) begin : g_mul
    mul_tag_t                 tag_d;
    logic signed [prod_w-1:0] prod_d;

    if (i == 0) begin : g_head
      assign tag_d  = tag_in;
      assign prod_d = rd_data * coef;
    end else begin : g_body
      assign tag_d  = tag_q[i-1];
      assign prod_d = prod_q[i-1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        tag_q[i] <= '0;
      end else begin
        tag_q[i] <= tag_d;
      end
    end

    always_ff @(posedge clk) begin
      prod_q[i] <= prod_d;
    end
  end

  assign tag_out  = tag_q[mul_stages-1];
  assign prod_out = prod_q[mul_stages-1];

  //////////////////////////////////////////////////
  // Accumulator

  // Guard bits take copies of the product sign
  assign prod_ext = {{(acc_w - prod_w){prod_out[prod_w-1]}}, prod_out};

  // First product of a sample restarts the sum
  assign acc_nxt = (tag_out.first ? '0 : acc_q) + prod_ext;

  always_ff @(posedge clk) begin
    if (tag_out.vld) begin
      acc_q <= acc_nxt;
    end
  end

  assign sum_done = tag_out.vld && tag_out.last;

  assign res_data.value = acc_q;
  assign res_data.last  = frame_last_q;

  //////////////////////////////////////////////////
  // Run sequencer

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      clr_start <= 1'b0;
      smp_take  <= 1'b0;
      res_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      clr_start <= 1'b0;
      smp_take  <= 1'b0;
      res_valid <= 1'b0;
      done      <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_clear;
            clr_start <= 1'b1;
          end
        end
        st_clear: begin
          // History is zeroed, so let the first sample in
          if (clr_done) begin
            state    <= st_calc;
            smp_take <= 1'b1;
          end
        end
        st_calc: begin
          // Sum is complete one cycle after the last product
          if (sum_done) begin
            res_valid <= 1'b1;
            if (frame_last_q) begin
              state <= st_idle;
              done  <= 1'b1;
            end else begin
              smp_take <= 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* hw/fir_result_port.sv */
// FIR result output port
module fir_result_port (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    res_valid,
  input  fir_stream_pkg::result_t res_data,
  output logic                    res_full,
  output logic                    res_req,
  input  logic                    res_ack,
  output fir_stream_pkg::result_t res
);
  import fir_stream_pkg::*;

  logic    full_q;
  result_t data_q;

  //////////////////////////////////////////////////
  // Output handshake

  // Entry stays full through the whole exchange, until ack falls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q  <= 1'b0;
      res_req <= 1'b0;
    end else begin
      if (res_valid) begin
        full_q  <= 1'b1;
        res_req <= 1'b1;
      end else if (res_req && res_ack) begin
        res_req <= 1'b0;
      end else if (full_q && !res_req && !res_ack) begin
        full_q <= 1'b0;
      end
    end
  end

  // Core never writes while full, so the held value cannot change under req
  always_ff @(posedge clk) begin
    if (res_valid) begin
      data_q <= res_data;
    end
  end

  assign res_full = full_q;
  assign res      = data_q;

endmodule

/* hw/fir_top.sv */
// FIR filter subsystem top
module fir_top #(
  // Must not exceed max_tap_aw in fir_stream_pkg
  parameter int tap_aw     = 5,
  parameter int mul_stages = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_req,
  output logic                    cmd_ack,
  input  fir_cfg_pkg::cmd_word_u  cmd,
  input  logic                    smp_req,
  output logic                    smp_ack,
  input  fir_stream_pkg::sample_t smp,
  output logic                    res_req,
  input  logic                    res_ack,
  output fir_stream_pkg::result_t res,
  output logic                    busy,
  output logic                    done
);
  import fir_stream_pkg::*;
  import fir_cfg_pkg::*;

  //////////////////////////////////////////////////
  // Internal wiring

  // Decoder to bank
  logic                       coef_we;
  logic [tap_aw-1:0]          coef_addr;
  logic signed [sample_w-1:0] coef_data;

  // Decoder to core and delay line
  logic                       start;
  run_cfg_t                   cfg;

  // Core and delay line
  logic                       clr_start;
  logic                       clr_done;
  logic                       smp_valid;
  logic                       smp_take;
  logic [tap_aw-1:0]          rd_offset;
  logic signed [sample_w-1:0] rd_data;

  // Core and bank read side
  logic [tap_aw-1:0]          tap_addr;
  logic signed [sample_w-1:0] tap_coef;

  // Core to result port
  logic                       res_valid;
  result_t                    res_data;
  logic                       res_full;

  fir_cmd_decoder #(
    .tap_aw (tap_aw)
  ) u_cmd_decoder (
    .clk,
    .rst_n,
    .cmd_req,
    .cmd_ack,
    .cmd,
    .busy,
    .coef_we,
    .coef_addr,
    .coef_data,
    .start,
    .cfg
  );

  fir_coef_bank #(
    .tap_aw (tap_aw)
  ) u_coef_bank (
    .clk,
    .rst_n,
    .coef_we,
    .coef_addr,
    .coef_data,
    .rd_addr (tap_addr),
    .rd_coef (tap_coef)
  );

  fir_delay_line #(
    .tap_aw (tap_aw)
  ) u_delay_line (
    .clk,
    .rst_n,
    .smp_req,
    .smp_ack,
    .smp,
    .clr_start,
    .tap_num (cfg.tap_num),
    .clr_done,
    .smp_valid,
    .smp_take,
    .rd_offset,
    .rd_data
  );

  fir_mac_core #(
    .tap_aw     (tap_aw),
    .mul_stages (mul_stages)
  ) u_mac_core (
    .clk,
    .rst_n,
    .start,
    .cfg,
    .busy,
    .done,
    .clr_start,
    .clr_done,
    .smp_valid,
    .smp_take,
    .rd_offset,
    .rd_data,
    .coef_addr (tap_addr),
    .coef      (tap_coef),
    .res_valid,
    .res_data,
    .res_full
  );

  fir_result_port u_result_port (
    .clk,
    .rst_n,
    .res_valid,
    .res_data,
    .res_full,
    .res_req,
    .res_ack,
    .res
  );

endmodule

/* bench/fir_tb.sv */
// FIR filter testbench
module fir_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import fir_stream_pkg::*;
  import fir_cfg_pkg::*;

  // Longest any single wait may last in clock cycles
  localparam int wait_limit = 2000;

  // Idle cycles after a run in which a stray result would show up
  localparam int quiet_cycles = 8;

  // Selectors for the DUT outputs that the wait loop can watch
  localparam int sig_cmd_ack = 0;
  localparam int sig_smp_ack = 1;
  localparam int sig_res_req = 2;
  localparam int sig_busy    = 3;

  logic      clk;
  logic      rst_n;
  logic      cmd_req;
  logic      cmd_ack;
  cmd_word_u cmd;
  logic      smp_req;
  logic      smp_ack;
  sample_t   smp;
  logic      res_req;
  logic      res_ack;
  result_t   res;
  logic      busy;
  logic      done;

  // Stimulus and expectations of the current test come from the test file
  string                      cur_test;
  cmd_word_u                  cmd_q [$];
  logic signed [sample_w-1:0] smp_q [$];
  longint                     exp_val_q [$];
  bit                         exp_last_q [$];
  int                         done_exp;

  int          err_cnt = 0;
  int          done_cnt = 0;
  int          pass_tests = 0;
  int          fail_tests = 0;
  logic [31:0] lcg_state;

  fir_top #(
    .tap_aw     (5),
    .mul_stages (2)
  ) dut (
    .clk,
    .rst_n,
    .cmd_req,
    .cmd_ack,
    .cmd,
    .smp_req,
    .smp_ack,
    .smp,
    .res_req,
    .res_ack,
    .res,
    .busy,
    .done
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Done is a one cycle pulse, so each negedge sees it at most once
  always @(negedge clk) begin
    if (rst_n && done) begin
      done_cnt++;
    end
  end

  //////////////////////////////////////////////////
  // Helpers

  // Linear congruential generator for the result ack delay
  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 16;
  endfunction

  function automatic logic port_level(input int sel);
    case (sel)
      sig_cmd_ack: return cmd_ack;
      sig_smp_ack: return smp_ack;
      sig_res_req: return res_req;
      default:     return busy;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("Stopped in test %s, %s", cur_test, why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic check(input string what, input logic signed [63:0] exp,
                       input logic signed [63:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s expected %0d actual %0d", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  // Polls on the falling edge, where DUT outputs are settled
  task automatic wait_level(input int sel, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (port_level(sel) !== level) begin
      if (cycles >= wait_limit) begin
        abort_run(what);
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Port threads

  task automatic send_cmds();
    foreach (cmd_q[i]) begin
      cmd     = cmd_q[i];
      cmd_req = 1'b1;
      wait_level(sig_cmd_ack, 1'b1, "command was never acknowledged");
      // A command may only be taken while no run is active
      check($sformatf("busy at command %0d ack", i), 0, busy);
      cmd_req = 1'b0;
      wait_level(sig_cmd_ack, 1'b0, "command ack stayed high");
    end
  endtask

  task automatic send_samples();
    foreach (smp_q[i]) begin
      smp.data = smp_q[i];
      smp_req  = 1'b1;
      wait_level(sig_smp_ack, 1'b1, "sample was never acknowledged");
      smp_req = 1'b0;
      wait_level(sig_smp_ack, 1'b0, "sample ack stayed high");
    end
  endtask

  task automatic take_results();
    int delay;
    foreach (exp_val_q[i]) begin
      wait_level(sig_res_req, 1'b1, "an expected result never arrived");
      check($sformatf("result %0d value", i), exp_val_q[i], $signed(res.value));
      check($sformatf("result %0d last", i), exp_last_q[i], res.last);
      // Back-pressure of 0 to 5 cycles before ack
      delay = next_rand() % 6;
      repeat (delay) @(negedge clk);
      res_ack = 1'b1;
      wait_level(sig_res_req, 1'b0, "result req stayed high after ack");
      res_ack = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequencing

  task automatic run_test();
    int err_before;
    int done_before;
    err_before  = err_cnt;
    done_before = done_cnt;
    fork
      send_cmds();
      send_samples();
      take_results();
    join
    wait_level(sig_busy, 1'b0, "busy stayed high after the last result");
    check("done pulses", done_exp, done_cnt - done_before);
    // Req stays up without an ack, so one look after the window catches a stray result
    repeat (quiet_cycles) @(negedge clk);
    check("extra result", 0, res_req);
    if (err_cnt == err_before) begin
      pass_tests++;
      $display("test %s ok", cur_test);
    end else begin
      fail_tests++;
      $display("test %s failed with %0d errors", cur_test, err_cnt - err_before);
    end
  endtask

  // Each test line starts a new test and runs the one before it
  task automatic load_tests();
    int        fd;
    int        n;
    int        f1;
    int        f2;
    longint    val;
    bit        have_test;
    string     line;
    string     tag;
    string     opname;
    cmd_word_u w;
    have_test = 1'b0;
    fd = $fopen("bench/fir_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open bench/fir_tests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      tag  = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%s", tag);
      if (n < 1 || tag.substr(0, 0) == "#") begin
        // Blank line or comment
      end else if (tag == "test") begin
        if (have_test) begin
          run_test();
        end
        cmd_q.delete();
        smp_q.delete();
        exp_val_q.delete();
        exp_last_q.delete();
        done_exp  = 0;
        have_test = 1'b1;
        n = $sscanf(line, "%s %s", tag, cur_test);
      end else if (tag == "cmd") begin
        n = $sscanf(line, "%s %s %d %d", tag, opname, f1, f2);
        w = '0;
        if (opname == "tap") begin
          w.tap_write.op   = op_tap_write;
          w.tap_write.addr = f1[7:0];
          w.tap_write.coef = f2[15:0];
        end else if (opname == "run") begin
          w.run.op        = op_run;
          w.run.tap_num   = f1[7:0];
          w.run.frame_len = f2[15:0];
        end else begin
          w.run.op = op_nop;
        end
        cmd_q.push_back(w);
      end else if (tag == "smp") begin
        n = $sscanf(line, "%s %d", tag, f1);
        smp_q.push_back(f1[15:0]);
      end else if (tag == "res") begin
        n = $sscanf(line, "%s %d %d", tag, val, f1);
        exp_val_q.push_back(val);
        exp_last_q.push_back(f1 != 0);
      end else if (tag == "done") begin
        done_exp++;
      end else begin
        abort_run($sformatf("test file has an unknown line kind %s", tag));
      end
    end
    $fclose(fd);
    if (have_test) begin
      run_test();
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    cmd_req   = 1'b0;
    cmd       = '0;
    smp_req   = 1'b0;
    smp       = '0;
    res_ack   = 1'b0;
    cur_test  = "reset";
    done_exp  = 0;
    lcg_state = 32'd59105;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    load_tests();
    $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_cnt);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* bench/fir_tests.txt */
# Line kinds are test NAME, cmd OP A B, smp X, res Y LAST and done
# OP tap takes address and coefficient, OP run takes tap count and frame length
test impulse
cmd tap 0 3
cmd tap 1 -7
cmd tap 2 100
cmd tap 3 12000
cmd run 4 6
smp 1
smp 0
smp 0
smp 0
smp 0
smp 0
res 3 0
res -7 0
res 100 0
res 12000 0
res 0 0
res 0 1
done

test signed_full_width
cmd tap 0 -32768
cmd tap 1 32767
cmd tap 2 -32768
cmd run 3 4
smp -32768
smp 32767
smp -32768
smp -32768
res 1073741824 0
res -2147418112 0
res 3221159937 0
res -1073676288 1
done

test clear_between_runs
cmd tap 0 2
cmd tap 1 5
cmd run 2 2
cmd run 2 2
smp 1000
smp -300
smp 7
smp 9
res 2000 0
res 4400 1
res 14 0
res 53 1
done
done

test frame_end
cmd nop 0 0
cmd tap 0 -4
cmd run 1 3
smp 5
smp -6
smp 7
res -20 0
res 24 0
res -28 1
done

test back_pressure
cmd tap 0 1
cmd tap 1 -2
cmd tap 2 3
cmd run 3 8
smp 10
smp 20
smp 30
smp 40
smp -50
smp 60
smp -70
smp 80
res 10 0
res 0 0
res 20 0
res 40 0
res -40 0
res 280 0
res -340 0
res 400 1
done

test command_blocking
cmd tap 0 1
cmd tap 1 1
cmd run 2 3
cmd tap 1 -1
cmd run 2 2
smp 4
smp 6
smp 8
smp 3
smp 10
res 4 0
res 10 0
res 14 1
res 3 0
res 7 1
done
done

/* src.f */
hw/fir_stream_pkg.sv
hw/fir_cfg_pkg.sv
hw/fir_cmd_decoder.sv
hw/fir_coef_bank.sv
hw/fir_delay_line.sv
hw/fir_mac_core.sv
hw/fir_result_port.sv
hw/fir_top.sv
bench/fir_tb.sv

/* Bender.yml */
package:
  name: fir_filter

sources:
  - hw/fir_stream_pkg.sv
  - hw/fir_cfg_pkg.sv
  - hw/fir_cmd_decoder.sv
  - hw/fir_coef_bank.sv
  - hw/fir_delay_line.sv
  - hw/fir_mac_core.sv
  - hw/fir_result_port.sv
  - hw/fir_top.sv
  - target: simulation
    files:
      - bench/fir_tb.sv
